// File: verilog/ntt_arith_pkg.sv
`default_nettype none

package ntt_arith_pkg;

    localparam int Q = 3329;
    localparam int COEFF_W = 12;

    // canonical coefficient, always in 0 .. Q-1
    typedef logic [COEFF_W-1:0] coeff_t;

    // 128^-1 mod q
    localparam coeff_t F_INV = 12'd3303;
    // primitive 256th root of unity mod q
    localparam coeff_t ZETA_ROOT = 12'd17;

    function automatic coeff_t mod_add(input coeff_t a, input coeff_t b);
        logic [COEFF_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= Q) begin
            s = s - (COEFF_W + 1)'(Q);
        end
        return s[COEFF_W-1:0];
    endfunction

    function automatic coeff_t mod_sub(input coeff_t a, input coeff_t b);
        logic [COEFF_W:0] d;
        // a + q - b never goes negative
        d = {1'b0, a} + (COEFF_W + 1)'(Q) - {1'b0, b};
        if (d >= Q) begin
            d = d - (COEFF_W + 1)'(Q);
        end
        return d[COEFF_W-1:0];
    endfunction

    function automatic coeff_t mod_mul(input coeff_t a, input coeff_t b);
        logic [2*COEFF_W-1:0] p;
        p = a * b;
        return coeff_t'(p % Q);
    endfunction

    function automatic logic [6:0] bitrev7(input logic [6:0] x);
        logic [6:0] r;
        for (int i = 0; i < 7; i++) begin
            r[i] = x[6-i];
        end
        return r;
    endfunction

    // 17^bitrev7(k) mod q by square and multiply
    function automatic coeff_t zeta(input logic [6:0] k);
        logic [6:0] e;
        coeff_t r;
        coeff_t base;
        e = bitrev7(k);
        r = 12'd1;
        base = ZETA_ROOT;
        for (int i = 0; i < 7; i++) begin
            if (e[i]) begin
                r = mod_mul(r, base);
            end
            base = mod_mul(base, base);
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// File: verilog/ntt_ctrl_pkg.sv
`default_nettype none

package ntt_ctrl_pkg;

    localparam int N = 256;
    localparam int NUM_BFU = 4;
    localparam int IDX_W = 8;
    localparam int LAYERS = 7;
    // butterfly steps per layer and per scale pass
    localparam int STEPS = N / (2 * NUM_BFU);
    localparam int STEP_W = $clog2(STEPS);

    typedef enum logic [1:0] {
        MODE_CT,
        MODE_GS,
        MODE_SCALE
    } bfu_mode_t;

    typedef struct packed {
        logic [IDX_W-1:0] lo;
        logic [IDX_W-1:0] hi;
    } pair_addr_t;

    typedef struct packed {
        logic                  valid;
        bfu_mode_t             mode;
        pair_addr_t            addr;
        ntt_arith_pkg::coeff_t twiddle;
    } bfu_cmd_t;

    // addresses ride along so writeback needs no side channel
    typedef struct packed {
        logic                  valid;
        pair_addr_t            addr;
        ntt_arith_pkg::coeff_t a;
        ntt_arith_pkg::coeff_t b;
    } bfu_result_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_RUN,
        S_SCALE,
        S_UNLOAD
    } seq_state_t;

endpackage

`default_nettype wire

// File: verilog/ntt_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module ntt_sequencer (
    input  wire                                i_clk,
    input  wire                                i_rst,
    input  wire                                i_valid,
    input  wire                                i_intt,
    output logic                               o_load_en,
    output logic [ntt_ctrl_pkg::IDX_W-1:0]     o_load_idx,
    output ntt_ctrl_pkg::bfu_cmd_t             o_cmd [ntt_ctrl_pkg::NUM_BFU],
    output logic [ntt_ctrl_pkg::IDX_W-1:0]     o_unload_idx,
    output logic                               o_valid,
    output logic                               o_busy
);

    // one layer has 2^LAYERS butterflies
    localparam int BIDX_W = ntt_ctrl_pkg::LAYERS;
    localparam int ZETAS = 1 << ntt_ctrl_pkg::LAYERS;

    ntt_ctrl_pkg::seq_state_t state;
    logic intt_q;
    // layer length held as log2
    logic [2:0] len_log;
    logic [BIDX_W-1:0] k_base;
    logic [ntt_ctrl_pkg::STEP_W-1:0] step;
    logic bubble;
    logic [ntt_ctrl_pkg::IDX_W-1:0] load_cnt;
    logic [ntt_ctrl_pkg::IDX_W-1:0] unload_cnt;
    logic last_step;
    logic last_layer;
    logic issue;
    ntt_arith_pkg::coeff_t zeta_rom [ZETAS];

    // twiddle table built at elaboration
    for (genvar z = 0; z < ZETAS; z++) begin : g_zeta
        assign zeta_rom[z] = ntt_arith_pkg::zeta(7'(z));
    end

    assign last_step = (int'(step) == ntt_ctrl_pkg::STEPS - 1);
    assign last_layer = intt_q ? (int'(len_log) == ntt_ctrl_pkg::LAYERS) : (len_log == 3'd1);
    assign issue = ((state == ntt_ctrl_pkg::S_RUN) || (state == ntt_ctrl_pkg::S_SCALE)) && !bubble;

    assign o_load_en = i_valid && ((state == ntt_ctrl_pkg::S_IDLE) ||
                                   (state == ntt_ctrl_pkg::S_LOAD));
    assign o_load_idx = load_cnt;
    assign o_unload_idx = unload_cnt;
    assign o_valid = (state == ntt_ctrl_pkg::S_UNLOAD);
    assign o_busy = (state != ntt_ctrl_pkg::S_IDLE);

    // pair addressing follows the kyber loop order
    always_comb begin
        logic [BIDX_W-1:0] bidx;
        logic [BIDX_W-1:0] grp;
        logic [BIDX_W-1:0] k;
        logic [ntt_ctrl_pkg::IDX_W-1:0] bw;
        logic [ntt_ctrl_pkg::IDX_W-1:0] mask;
        logic [ntt_ctrl_pkg::IDX_W-1:0] lo;
        mask = (8'd1 << len_log) - 8'd1;
        for (int i = 0; i < ntt_ctrl_pkg::NUM_BFU; i++) begin
            bidx = BIDX_W'(int'(step) * ntt_ctrl_pkg::NUM_BFU + i);
            bw = {1'b0, bidx};
            grp = BIDX_W'(bw >> len_log);
            lo = ((bw >> len_log) << (len_log + 3'd1)) | (bw & mask);
            // inverse walks the groups with k counting down
            k = intt_q ? k_base - grp : k_base + grp;
            o_cmd[i].valid = issue;
            if (state == ntt_ctrl_pkg::S_SCALE) begin
                o_cmd[i].mode = ntt_ctrl_pkg::MODE_SCALE;
                o_cmd[i].addr.lo = {bidx, 1'b0};
                o_cmd[i].addr.hi = {bidx, 1'b1};
                o_cmd[i].twiddle = ntt_arith_pkg::F_INV;
            end else begin
                o_cmd[i].mode = intt_q ? ntt_ctrl_pkg::MODE_GS : ntt_ctrl_pkg::MODE_CT;
                o_cmd[i].addr.lo = lo;
                o_cmd[i].addr.hi = lo | (8'd1 << len_log);
                o_cmd[i].twiddle = zeta_rom[k];
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= ntt_ctrl_pkg::S_IDLE;
            intt_q <= 1'b0;
            len_log <= 3'd0;
            k_base <= '0;
            step <= '0;
            bubble <= 1'b0;
            load_cnt <= '0;
            unload_cnt <= '0;
        end else begin
            case (state)
                ntt_ctrl_pkg::S_IDLE: begin
                    if (i_valid) begin
                        intt_q <= i_intt;
                        len_log <= i_intt ? 3'd1 : 3'(ntt_ctrl_pkg::LAYERS);
                        k_base <= i_intt ? {BIDX_W{1'b1}} : BIDX_W'(1);
                        load_cnt <= load_cnt + 1'b1;
                        state <= ntt_ctrl_pkg::S_LOAD;
                    end
                end
                ntt_ctrl_pkg::S_LOAD: begin
                    if (i_valid) begin
                        // counter wraps back to 0 on the last word
                        load_cnt <= load_cnt + 1'b1;
                        if (int'(load_cnt) == ntt_ctrl_pkg::N - 1) begin
                            state <= ntt_ctrl_pkg::S_RUN;
                        end
                    end
                end
                ntt_ctrl_pkg::S_RUN,
                ntt_ctrl_pkg::S_SCALE: begin
                    if (!bubble) begin
                        step <= step + 1'b1;
                        bubble <= last_step;
                    end else begin
                        // last writeback of the layer lands here
                        bubble <= 1'b0;
                        if (state == ntt_ctrl_pkg::S_SCALE) begin
                            state <= ntt_ctrl_pkg::S_UNLOAD;
                        end else if (!last_layer) begin
                            len_log <= intt_q ? len_log + 3'd1 : len_log - 3'd1;
                            k_base <= intt_q ? k_base >> 1 : k_base << 1;
                        end else begin
                            state <= intt_q ? ntt_ctrl_pkg::S_SCALE : ntt_ctrl_pkg::S_UNLOAD;
                        end
                    end
                end
                ntt_ctrl_pkg::S_UNLOAD: begin
                    unload_cnt <= unload_cnt + 1'b1;
                    if (int'(unload_cnt) == ntt_ctrl_pkg::N - 1) begin
                        state <= ntt_ctrl_pkg::S_IDLE;
                    end
                end
                default: begin
                    state <= ntt_ctrl_pkg::S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/butterfly_unit.sv
`timescale 1ns/1ns
`default_nettype none

module butterfly_unit (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire ntt_ctrl_pkg::bfu_cmd_t  i_cmd,
    input  wire ntt_arith_pkg::coeff_t   i_a,
    input  wire ntt_arith_pkg::coeff_t   i_b,
    output ntt_ctrl_pkg::bfu_result_t    o_res
);

    ntt_arith_pkg::coeff_t diff;
    ntt_arith_pkg::coeff_t mul_in;
    ntt_arith_pkg::coeff_t prod_a;
    ntt_arith_pkg::coeff_t prod_b;
    ntt_arith_pkg::coeff_t res_a;
    ntt_arith_pkg::coeff_t res_b;
    logic valid_q;
    ntt_ctrl_pkg::pair_addr_t addr_q;
    ntt_arith_pkg::coeff_t a_q;
    ntt_arith_pkg::coeff_t b_q;

    // upper multiplier is shared by ct, gs and scale
    assign diff = ntt_arith_pkg::mod_sub(i_b, i_a);
    assign mul_in = (i_cmd.mode == ntt_ctrl_pkg::MODE_GS) ? diff : i_b;
    assign prod_b = ntt_arith_pkg::mod_mul(i_cmd.twiddle, mul_in);
    // lower multiplier only matters in scale mode
    assign prod_a = ntt_arith_pkg::mod_mul(i_cmd.twiddle, i_a);

    always_comb begin
        case (i_cmd.mode)
            ntt_ctrl_pkg::MODE_CT: begin
                res_a = ntt_arith_pkg::mod_add(i_a, prod_b);
                res_b = ntt_arith_pkg::mod_sub(i_a, prod_b);
            end
            ntt_ctrl_pkg::MODE_GS: begin
                res_a = ntt_arith_pkg::mod_add(i_a, i_b);
                res_b = prod_b;
            end
            default: begin
                res_a = prod_a;
                res_b = prod_b;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_cmd.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        addr_q <= i_cmd.addr;
        a_q <= res_a;
        b_q <= res_b;
    end

    assign o_res = '{valid: valid_q, addr: addr_q, a: a_q, b: b_q};

endmodule

`default_nettype wire

// File: verilog/coeff_bank.sv
`timescale 1ns/1ns
`default_nettype none

module coeff_bank (
    input  wire                                i_clk,
    input  wire                                i_rst,
    input  wire                                i_load_en,
    input  wire [ntt_ctrl_pkg::IDX_W-1:0]      i_load_idx,
    input  wire ntt_arith_pkg::coeff_t         i_load_data,
    input  wire ntt_ctrl_pkg::pair_addr_t      i_rd_addr [ntt_ctrl_pkg::NUM_BFU],
    output ntt_arith_pkg::coeff_t              o_rd_a [ntt_ctrl_pkg::NUM_BFU],
    output ntt_arith_pkg::coeff_t              o_rd_b [ntt_ctrl_pkg::NUM_BFU],
    input  wire ntt_ctrl_pkg::bfu_result_t     i_wb [ntt_ctrl_pkg::NUM_BFU],
    input  wire [ntt_ctrl_pkg::IDX_W-1:0]      i_unload_idx,
    output ntt_arith_pkg::coeff_t              o_unload_data
);

    ntt_arith_pkg::coeff_t mem [ntt_ctrl_pkg::N];
    ntt_arith_pkg::coeff_t mem_nxt [ntt_ctrl_pkg::N];

    // next contents: load and writeback never overlap in time
    always_comb begin
        for (int e = 0; e < ntt_ctrl_pkg::N; e++) begin
            mem_nxt[e] = mem[e];
        end
        if (i_load_en) begin
            mem_nxt[i_load_idx] = i_load_data;
        end
        for (int i = 0; i < ntt_ctrl_pkg::NUM_BFU; i++) begin
            if (i_wb[i].valid) begin
                mem_nxt[i_wb[i].addr.lo] = i_wb[i].a;
                mem_nxt[i_wb[i].addr.hi] = i_wb[i].b;
            end
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int e = 0; e < ntt_ctrl_pkg::N; e++) begin
                mem[e] <= '0;
            end
        end else begin
            for (int e = 0; e < ntt_ctrl_pkg::N; e++) begin
                mem[e] <= mem_nxt[e];
            end
        end
    end

    // operand read for the butterfly array
    always_comb begin
        for (int i = 0; i < ntt_ctrl_pkg::NUM_BFU; i++) begin
            o_rd_a[i] = mem[i_rd_addr[i].lo];
            o_rd_b[i] = mem[i_rd_addr[i].hi];
        end
    end

    assign o_unload_data = mem[i_unload_idx];

endmodule

`default_nettype wire

// File: verilog/ntt_core.sv
`timescale 1ns/1ns
`default_nettype none

module ntt_core (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire                          i_valid,
    input  wire                          i_intt,
    input  wire ntt_arith_pkg::coeff_t   i_data,
    output logic                         o_valid,
    output ntt_arith_pkg::coeff_t        o_data,
    output logic                         o_busy
);

    logic load_en;
    logic [ntt_ctrl_pkg::IDX_W-1:0] load_idx;
    logic [ntt_ctrl_pkg::IDX_W-1:0] unload_idx;
    ntt_ctrl_pkg::bfu_cmd_t cmd [ntt_ctrl_pkg::NUM_BFU];
    ntt_ctrl_pkg::pair_addr_t rd_addr [ntt_ctrl_pkg::NUM_BFU];
    ntt_arith_pkg::coeff_t rd_a [ntt_ctrl_pkg::NUM_BFU];
    ntt_arith_pkg::coeff_t rd_b [ntt_ctrl_pkg::NUM_BFU];
    ntt_ctrl_pkg::bfu_result_t res [ntt_ctrl_pkg::NUM_BFU];

    ntt_sequencer u_seq (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (i_valid),
        .i_intt       (i_intt),
        .o_load_en    (load_en),
        .o_load_idx   (load_idx),
        .o_cmd        (cmd),
        .o_unload_idx (unload_idx),
        .o_valid      (o_valid),
        .o_busy       (o_busy)
    );

    // one set of results writes back while the next set is read
    for (genvar i = 0; i < ntt_ctrl_pkg::NUM_BFU; i++) begin : g_bfu
        assign rd_addr[i] = cmd[i].addr;

        butterfly_unit u_bfu (
            .i_clk (i_clk),
            .i_rst (i_rst),
            .i_cmd (cmd[i]),
            .i_a   (rd_a[i]),
            .i_b   (rd_b[i]),
            .o_res (res[i])
        );
    end

    coeff_bank u_bank (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_load_en     (load_en),
        .i_load_idx    (load_idx),
        .i_load_data   (i_data),
        .i_rd_addr     (rd_addr),
        .o_rd_a        (rd_a),
        .o_rd_b        (rd_b),
        .i_wb          (res),
        .i_unload_idx  (unload_idx),
        .o_unload_data (o_data)
    );

endmodule

`default_nettype wire

// File: test/tb_ntt_model.svh
`ifndef TB_NTT_MODEL_SVH
`define TB_NTT_MODEL_SVH

// working polynomial for the reference transforms
int model_poly [ntt_ctrl_pkg::N];

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

function automatic int add_q(input int a, input int b);
    return (a + b) % ntt_arith_pkg::Q;
endfunction

function automatic int sub_q(input int a, input int b);
    return (a - b + ntt_arith_pkg::Q) % ntt_arith_pkg::Q;
endfunction

function automatic int mul_q(input int a, input int b);
    return (a * b) % ntt_arith_pkg::Q;
endfunction

// root raised to the 7-bit reversal of k, by plain repeated products
function automatic int twiddle_of(input int k);
    int e;
    int r;
    e = 0;
    for (int i = 0; i < 7; i++) begin
        if (((k >> i) & 1) == 1) begin
            e = e | (1 << (6 - i));
        end
    end
    r = 1;
    for (int i = 0; i < e; i++) begin
        r = mul_q(r, int'(ntt_arith_pkg::ZETA_ROOT));
    end
    return r;
endfunction

// kyber forward ntt, cooley-tukey, len 128 down to 2
task automatic model_ntt();
    int k;
    int t;
    int zeta;
    k = 1;
    for (int len = 128; len >= 2; len = len / 2) begin
        for (int start = 0; start < ntt_ctrl_pkg::N; start = start + 2 * len) begin
            zeta = twiddle_of(k);
            k++;
            for (int j = start; j < start + len; j++) begin
                t = mul_q(zeta, model_poly[j + len]);
                model_poly[j + len] = sub_q(model_poly[j], t);
                model_poly[j] = add_q(model_poly[j], t);
            end
        end
    end
endtask

// kyber inverse ntt, gentleman-sande, len 2 up to 128, then scaling
task automatic model_intt();
    int k;
    int t;
    int zeta;
    k = 127;
    for (int len = 2; len <= 128; len = len * 2) begin
        for (int start = 0; start < ntt_ctrl_pkg::N; start = start + 2 * len) begin
            zeta = twiddle_of(k);
            k--;
            for (int j = start; j < start + len; j++) begin
                t = model_poly[j];
                model_poly[j] = add_q(t, model_poly[j + len]);
                model_poly[j + len] = mul_q(zeta, sub_q(model_poly[j + len], t));
            end
        end
    end
    for (int i = 0; i < ntt_ctrl_pkg::N; i++) begin
        model_poly[i] = mul_q(model_poly[i], int'(ntt_arith_pkg::F_INV));
    end
endtask

`endif

// File: test/tb_ntt.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ntt;

    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS = 6;
    localparam int TEST_CYCLES = 1000;
    localparam int WAIT_LIMIT = 1000;

    logic i_clk;
    logic i_rst;
    logic i_valid;
    logic i_intt;
    ntt_arith_pkg::coeff_t i_data;
    logic o_valid;
    ntt_arith_pkg::coeff_t o_data;
    logic o_busy;

    logic [15:0] lfsr;
    int stim [ntt_ctrl_pkg::N];
    int got [ntt_ctrl_pkg::N];

    `include "tb_ntt_model.svh"

    ntt_core dut (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_intt  (i_intt),
        .i_data  (i_data),
        .o_valid (o_valid),
        .o_data  (o_data),
        .o_busy  (o_busy)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    initial begin
        #(NUM_TESTS * TEST_CYCLES * 2 * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES * 2);
        $display("Done: errors found");
        $fatal(1);
    end

    // inputs change and outputs are read 1 ns after the edge
    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic check_value(input string test, input string what, input int exp,
                               input int act);
        assert (exp == act) else begin
            $display("[FAIL] %s: %s expected %0d actual %0d", test, what, exp, act);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // one lfsr step for each of the 12 bits
    function automatic int random_coeff();
        logic [11:0] v;
        v = '0;
        for (int b = 0; b < 12; b++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[10:0], lfsr[0]};
        end
        return int'(v) % ntt_arith_pkg::Q;
    endfunction

    task automatic fill_random();
        for (int i = 0; i < ntt_ctrl_pkg::N; i++) begin
            stim[i] = random_coeff();
            model_poly[i] = stim[i];
        end
    endtask

    // mode flag only holds its value on the first word
    task automatic load_poly(input logic intt, input bit gaps);
        for (int i = 0; i < ntt_ctrl_pkg::N; i++) begin
            if (gaps) begin
                lfsr = lfsr_next(lfsr);
                if (lfsr[0]) begin
                    i_valid = 1'b0;
                    next_cycle();
                end
            end
            i_valid = 1'b1;
            i_intt = (i == 0) ? intt : ~intt;
            i_data = ntt_arith_pkg::coeff_t'(stim[i]);
            next_cycle();
        end
        i_valid = 1'b0;
        check_value("load_poly", "o_busy after load", 1, int'(o_busy));
    endtask

    task automatic capture_poly(input string test);
        int waited;
        waited = 0;
        while (!o_valid && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        assert (o_valid) else begin
            $display("%s: o_valid did not rise within %0d cycles", test, WAIT_LIMIT);
            $display("Done: errors found");
            $fatal(1);
        end
        for (int i = 0; i < ntt_ctrl_pkg::N; i++) begin
            check_value(test, "o_valid during unload", 1, int'(o_valid));
            got[i] = int'(o_data);
            next_cycle();
        end
        check_value(test, "o_valid after unload", 0, int'(o_valid));
        check_value(test, "o_busy after unload", 0, int'(o_busy));
    endtask

    // stray words while the core computes until output starts
    task automatic offer_junk();
        while (!o_valid) begin
            i_valid = 1'b1;
            i_intt = ~i_intt;
            i_data = ntt_arith_pkg::coeff_t'(random_coeff());
            next_cycle();
        end
        i_valid = 1'b0;
    endtask

    task automatic compare_model(input string test);
        for (int i = 0; i < ntt_ctrl_pkg::N; i++) begin
            check_value(test, $sformatf("coeff %0d", i), model_poly[i], got[i]);
        end
    endtask

    task automatic idle_after_reset();
        for (int c = 0; c < 20; c++) begin
            check_value("reset_idle", "o_valid", 0, int'(o_valid));
            check_value("reset_idle", "o_busy", 0, int'(o_busy));
            next_cycle();
        end
    endtask

    task automatic forward_random();
        fill_random();
        model_ntt();
        load_poly(1'b0, 1'b0);
        capture_poly("forward_ntt");
        compare_model("forward_ntt");
    endtask

    task automatic inverse_with_gaps();
        fill_random();
        model_intt();
        load_poly(1'b1, 1'b1);
        capture_poly("inverse_gaps");
        compare_model("inverse_gaps");
    endtask

    task automatic round_trip();
        int orig [ntt_ctrl_pkg::N];
        fill_random();
        orig = stim;
        load_poly(1'b0, 1'b0);
        capture_poly("round_trip_fwd");
        stim = got;
        load_poly(1'b1, 1'b1);
        capture_poly("round_trip_inv");
        for (int i = 0; i < ntt_ctrl_pkg::N; i++) begin
            check_value("round_trip", $sformatf("coeff %0d", i), orig[i], got[i]);
        end
    endtask

    task automatic const_one_while_busy();
        for (int i = 0; i < ntt_ctrl_pkg::N; i++) begin
            stim[i] = (i == 0) ? 1 : 0;
        end
        load_poly(1'b0, 1'b0);
        fork
            offer_junk();
            capture_poly("const_one");
        join
        // 1 is its own residue for every quadratic factor so only even slots hold 1
        for (int i = 0; i < ntt_ctrl_pkg::N; i++) begin
            check_value("const_one", $sformatf("coeff %0d", i), (i % 2 == 0) ? 1 : 0, got[i]);
        end
    endtask

    initial begin
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_valid = 1'b0;
        i_intt = 1'b0;
        i_data = '0;
        lfsr = 16'd80;
        repeat (16) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        next_cycle();
        idle_after_reset();
        forward_random();
        inverse_with_gaps();
        round_trip();
        const_one_while_busy();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+test
verilog/ntt_arith_pkg.sv
verilog/ntt_ctrl_pkg.sv
verilog/ntt_sequencer.sv
verilog/butterfly_unit.sv
verilog/coeff_bank.sv
verilog/ntt_core.sv
test/tb_ntt.sv
